//--- files.f
fe_pkg.sv
instr_scan.sv
fetch_stage.sv
bht.sv
branch_predict.sv
pc_gen.sv
fetch_queue.sv
frontend.sv
tb_frontend.sv

//--- tb_frontend.sv
`timescale 1ns/100ps

module tb_frontend;
  import fe_pkg::*;

  // ----------------------------------------
  // test table
  // ----------------------------------------
  typedef enum logic [1:0] {
    EV_BOOT,
    EV_MISPREDICT,
    EV_TRAP,
    EV_COMMIT
  } start_e;

  // one row per test with 12-bit addresses
  // resume is the first pc expected after the start event
  typedef struct packed {
    start_e      ev;
    logic [11:0] tgt;
    logic        halt;
    logic        rnd;
    logic        flush_bp;
    logic [1:0]  train_n;
    logic [11:0] train_pc;
    logic [11:0] resume;
    logic [7:0]  n;
  } row_t;

  localparam int          N_ROWS     = 9;
  // cycle budget of a single row
  localparam int          ROW_BUDGET = 250;
  localparam int          MAX_CYCLES = N_ROWS * ROW_BUDGET;
  localparam logic [31:0] NOP        = 32'h0000_0013;

  // dut ports
  logic                   clk_i;
  logic                   rst_ni;
  logic [XLEN-1:0]        boot_addr_i;
  logic                   flush_bp_i;
  resolve_t               resolve_i;
  logic                   eret_i;
  logic [XLEN-1:0]        epc_i;
  logic                   ex_valid_i;
  logic [XLEN-1:0]        trap_vector_i;
  logic                   set_pc_commit_i;
  logic [XLEN-1:0]        pc_commit_i;
  logic                   halt_i;
  logic                   fetch_req_o;
  logic [XLEN-1:0]        fetch_addr_o;
  logic                   fetch_valid_i;
  logic [FETCH_WIDTH-1:0] fetch_data_i;
  fetch_entry_t           fetch_entry_o;
  logic                   fetch_entry_valid_o;
  logic                   fetch_entry_ready_i;

  // program image and its control flow
  // kind 1 is a jal and kind 2 a branch
  logic [31:0] prog [64];
  int          ctl_kind [64];
  int          ctl_off [64];
  // mirrored history table
  logic [15:0] bv;
  logic [1:0]  bc [16];
  // expected stream of the running test
  logic [31:0] exp_pc [64];
  logic [31:0] exp_instr [64];
  logic        exp_bp [64];
  int          exp_n, got, errors, n_pass, n_fail, err_start, cycles, r, t;
  logic        active, use_rnd, mem_req_q;
  logic [31:0] mem_addr_q, seed;
  row_t        rows [N_ROWS];
  row_t        row;

  frontend frontend_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr_i),
    .flush_bp_i          (flush_bp_i),
    .resolve_i           (resolve_i),
    .eret_i              (eret_i),
    .epc_i               (epc_i),
    .ex_valid_i          (ex_valid_i),
    .trap_vector_i       (trap_vector_i),
    .set_pc_commit_i     (set_pc_commit_i),
    .pc_commit_i         (pc_commit_i),
    .halt_i              (halt_i),
    .fetch_req_o         (fetch_req_o),
    .fetch_addr_o        (fetch_addr_o),
    .fetch_valid_i       (fetch_valid_i),
    .fetch_data_i        (fetch_data_i),
    .fetch_entry_o       (fetch_entry_o),
    .fetch_entry_valid_o (fetch_entry_valid_o),
    .fetch_entry_ready_i (fetch_entry_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // words past the array read as nop
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    if (a < 32'h100) return prog[a[7:2]];
    return NOP;
  endfunction

  function automatic void place_jal(input int w, input int off);
    logic [20:0] o;
    o = off[20:0];
    prog[w] = {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'b1101111};
    ctl_kind[w] = 1;
    ctl_off[w] = off;
  endfunction

  // compares x1 with x2
  function automatic void place_branch(input int w, input int off, input logic [2:0] f3);
    logic [12:0] o;
    o = off[12:0];
    prog[w] = {o[12], o[10:5], 5'd2, 5'd1, f3, o[4:1], o[11], 7'b1100011};
    ctl_kind[w] = 2;
    ctl_off[w] = off;
  endfunction

  // first outcome seeds a weak 2-bit counter
  function automatic void train_bht(input logic [31:0] pc, input logic taken);
    logic [3:0] i;
    i = pc[5:2];
    if (!bv[i]) bc[i] = taken ? 2'b10 : 2'b01;
    else if (taken && bc[i] != 2'b11) bc[i] = bc[i] + 2'b01;
    else if (!taken && bc[i] != 2'b00) bc[i] = bc[i] - 2'b01;
    bv[i] = 1'b1;
  endfunction

  // walk the program with the prediction rules
  function automatic void build_expected(input logic [31:0] start, input int n);
    logic [31:0] pc;
    logic        tk;
    logic        in_prog;
    int          w;
    pc = start;
    for (int k = 0; k < n; k++) begin
      in_prog = (pc < 32'h100);
      w = int'(pc[7:2]);
      tk = 1'b0;
      if (in_prog && ctl_kind[w] == 1) tk = 1'b1;
      // a trained counter overrides the backward rule
      if (in_prog && ctl_kind[w] == 2) tk = bv[pc[5:2]] ? bc[pc[5:2]][1] : (ctl_off[w] < 0);
      exp_pc[k] = pc;
      exp_instr[k] = mem_word(pc);
      exp_bp[k] = tk;
      pc = tk ? pc + 32'(ctl_off[w]) : pc + 32'd4;
    end
  endfunction

  // advance to the next falling edge with redirects idle and fresh ready
  task automatic step();
    logic [31:0] rv;
    @(negedge clk_i);
    rv = lcg_next();
    fetch_entry_ready_i = use_rnd ? rv[16] : 1'b1;
    flush_bp_i = 1'b0;
    resolve_i = '0;
    eret_i = 1'b0;
    ex_valid_i = 1'b0;
    set_pc_commit_i = 1'b0;
    halt_i = 1'b0;
  endtask

  // ----------------------------------------
  // memory model with one cycle latency
  // ----------------------------------------
  always @(posedge clk_i) begin
    mem_req_q  <= fetch_req_o;
    mem_addr_q <= fetch_addr_o;
  end

  always @(negedge clk_i) begin
    fetch_valid_i <= mem_req_q;
    fetch_data_i  <= {mem_word(mem_addr_q + 32'd4), mem_word(mem_addr_q)};
  end

  // decode side compares every transfer of the running test
  always @(posedge clk_i) begin
    if (active && fetch_entry_valid_o && fetch_entry_ready_i && got < exp_n) begin
      if (fetch_entry_o.pc !== exp_pc[got] || fetch_entry_o.instr !== exp_instr[got] ||
          fetch_entry_o.bp_taken !== exp_bp[got]) begin
        $display("** Error at %0t: entry %0d pc %h instr %h bp %b, expected %h %h %b",
                 $time, got, fetch_entry_o.pc, fetch_entry_o.instr, fetch_entry_o.bp_taken,
                 exp_pc[got], exp_instr[got], exp_bp[got]);
        errors++;
      end
      got++;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles with tests unfinished", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    rst_ni = 1'b0;
    boot_addr_i = '0;
    flush_bp_i = 1'b0;
    resolve_i = '0;
    eret_i = 1'b0;
    epc_i = '0;
    ex_valid_i = 1'b0;
    trap_vector_i = '0;
    set_pc_commit_i = 1'b0;
    pc_commit_i = '0;
    halt_i = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_data_i = '0;
    fetch_entry_ready_i = 1'b0;
    mem_req_q = 1'b0;
    mem_addr_q = '0;
    seed = 32'h7b09;
    active = 1'b0;
    use_rnd = 1'b0;
    exp_n = 0;
    got = 0;
    errors = 0;
    n_pass = 0;
    n_fail = 0;
    cycles = 0;
    bv = '0;
    // addi x1, x0, index everywhere
    for (int i = 0; i < 64; i++) begin
      prog[i] = {12'(i), 5'd0, 3'b000, 5'd1, 7'b0010011};
      ctl_kind[i] = 0;
      ctl_off[i] = 0;
    end
    place_branch(41, 16, 3'b001);
    place_branch(43, -12, 3'b000);
    place_jal(48, 32);

    //           ev             tgt      hlt   rnd   fbp   trn   trn_pc   resume   n
    rows[0] = {EV_BOOT,       12'h020, 1'b0, 1'b0, 1'b0, 2'd0, 12'h000, 12'h020, 8'd8};
    rows[1] = {EV_MISPREDICT, 12'h004, 1'b0, 1'b1, 1'b0, 2'd0, 12'h000, 12'h004, 8'd36};
    rows[2] = {EV_COMMIT,     12'h0b4, 1'b0, 1'b0, 1'b0, 2'd0, 12'h000, 12'h0b8, 8'd6};
    rows[3] = {EV_TRAP,       12'h0a0, 1'b0, 1'b0, 1'b0, 2'd0, 12'h000, 12'h0a0, 8'd10};
    rows[4] = {EV_MISPREDICT, 12'h0a0, 1'b0, 1'b0, 1'b0, 2'd2, 12'h0a4, 12'h0a0, 8'd7};
    rows[5] = {EV_COMMIT,     12'h0a0, 1'b1, 1'b0, 1'b1, 2'd0, 12'h000, 12'h0a0, 8'd6};
    rows[6] = {EV_TRAP,       12'h040, 1'b0, 1'b1, 1'b0, 2'd0, 12'h000, 12'h040, 8'd12};
    rows[7] = {EV_COMMIT,     12'h010, 1'b1, 1'b1, 1'b0, 2'd0, 12'h000, 12'h010, 8'd8};
    rows[8] = {EV_COMMIT,     12'h010, 1'b0, 1'b0, 1'b0, 2'd0, 12'h000, 12'h014, 8'd8};

    for (r = 0; r < N_ROWS; r++) begin
      row = rows[r];
      use_rnd = row.rnd;
      // taken outcomes for the trained branch
      for (t = 0; t < int'(row.train_n); t++) begin
        step();
        resolve_i.valid = 1'b1;
        resolve_i.pc = 32'(row.train_pc);
        resolve_i.is_branch = 1'b1;
        resolve_i.taken = 1'b1;
        train_bht(32'(row.train_pc), 1'b1);
      end
      if (row.flush_bp) begin
        step();
        flush_bp_i = 1'b1;
        bv = '0;
      end
      step();
      case (row.ev)
        EV_BOOT: begin
          rst_ni = 1'b0;
          boot_addr_i = 32'(row.tgt);
          bv = '0;
          repeat (3) begin
            step();
            if (fetch_req_o !== 1'b0 || fetch_entry_valid_o !== 1'b0) begin
              $display("** Error at %0t: request or entry valid during reset", $time);
              errors++;
            end
          end
          rst_ni = 1'b1;
        end
        EV_MISPREDICT: begin
          resolve_i.valid = 1'b1;
          resolve_i.mispredict = 1'b1;
          resolve_i.target = 32'(row.tgt);
        end
        // eret loses against the exception
        EV_TRAP: begin
          ex_valid_i = 1'b1;
          trap_vector_i = 32'(row.tgt);
          eret_i = 1'b1;
          epc_i = 32'h0000_00c4;
        end
        default: begin
          set_pc_commit_i = 1'b1;
          pc_commit_i = 32'(row.tgt);
          halt_i = row.halt;
        end
      endcase
      build_expected(32'(row.resume), int'(row.n));
      exp_n = int'(row.n);
      got = 0;
      err_start = errors;
      // checking starts once the flush edge has passed
      step();
      active = 1'b1;
      while (got < exp_n) step();
      active = 1'b0;
      if (errors == err_start) n_pass++;
      else n_fail++;
      $display("test %0d: %0d entries checked, %0d errors", r, exp_n, errors - err_start);
    end

    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- frontend.sv
`timescale 1ns/100ps

module frontend (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [fe_pkg::XLEN-1:0]        boot_addr_i,
  input  logic                           flush_bp_i,
  // back end redirects
  input  fe_pkg::resolve_t               resolve_i,
  input  logic                           eret_i,
  input  logic [fe_pkg::XLEN-1:0]        epc_i,
  input  logic                           ex_valid_i,
  input  logic [fe_pkg::XLEN-1:0]        trap_vector_i,
  input  logic                           set_pc_commit_i,
  input  logic [fe_pkg::XLEN-1:0]        pc_commit_i,
  input  logic                           halt_i,
  // instruction memory
  output logic                           fetch_req_o,
  output logic [fe_pkg::XLEN-1:0]        fetch_addr_o,
  input  logic                           fetch_valid_i,
  input  logic [fe_pkg::FETCH_WIDTH-1:0] fetch_data_i,
  // decode
  output fe_pkg::fetch_entry_t           fetch_entry_o,
  output logic                           fetch_entry_valid_o,
  input  logic                           fetch_entry_ready_i
);
  import fe_pkg::*;

  fetch_slot_t  [SLOTS-1:0]           slots;
  scan_t        [SLOTS-1:0]           scan;
  bht_pred_t    [SLOTS-1:0]           bht_pred;
  fetch_entry_t [SLOTS-1:0]           entries;
  logic [SLOTS-1:0][XLEN-1:0]         slot_pc;
  logic [SLOTS-1:0]                   push;
  logic [XLEN-1:0]                    req_addr_q;
  logic [XLEN-1:0]                    bp_target;
  logic                               bp_valid;
  logic                               fq_ready;
  logic                               drop;
  logic                               flush;

  // ----------------------------------------
  // pc and memory request
  // ----------------------------------------
  pc_gen pc_gen_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .boot_addr_i     (boot_addr_i),
    .resolve_i       (resolve_i),
    .eret_i          (eret_i),
    .epc_i           (epc_i),
    .ex_valid_i      (ex_valid_i),
    .trap_vector_i   (trap_vector_i),
    .set_pc_commit_i (set_pc_commit_i),
    .pc_commit_i     (pc_commit_i),
    .halt_i          (halt_i),
    .bp_valid_i      (bp_valid),
    .bp_target_i     (bp_target),
    .fq_ready_i      (fq_ready),
    .fetch_req_o     (fetch_req_o),
    .fetch_addr_o    (fetch_addr_o),
    .req_addr_q_o    (req_addr_q),
    .drop_o          (drop),
    .flush_o         (flush)
  );

  fetch_stage fetch_stage_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_valid_i (fetch_valid_i),
    .fetch_data_i  (fetch_data_i),
    .fetch_addr_i  (req_addr_q),
    .drop_i        (drop),
    .flush_i       (flush),
    .slots_o       (slots)
  );

  // one scanner per slot
  for (genvar i = 0; i < SLOTS; i++) begin : gen_scan
    assign slot_pc[i] = slots[i].pc;
    instr_scan instr_scan_inst (
      .instr_i (slots[i].instr),
      .scan_o  (scan[i])
    );
  end

  // ----------------------------------------
  // prediction and queue
  // ----------------------------------------
  bht bht_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_bp_i (flush_bp_i),
    .pc_i       (slot_pc),
    .pred_o     (bht_pred),
    .resolve_i  (resolve_i)
  );

  branch_predict branch_predict_inst (
    .slots_i     (slots),
    .scan_i      (scan),
    .bht_pred_i  (bht_pred),
    .bp_valid_o  (bp_valid),
    .bp_target_o (bp_target),
    .push_o      (push),
    .entries_o   (entries)
  );

  fetch_queue fetch_queue_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush),
    .push_i              (push),
    .entries_i           (entries),
    .fq_ready_o          (fq_ready),
    .fetch_entry_o       (fetch_entry_o),
    .fetch_entry_valid_o (fetch_entry_valid_o),
    .fetch_entry_ready_i (fetch_entry_ready_i)
  );

endmodule

//--- fetch_queue.sv
`timescale 1ns/100ps

module fetch_queue (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     flush_i,
  input  logic [fe_pkg::SLOTS-1:0]                 push_i,
  input  fe_pkg::fetch_entry_t [fe_pkg::SLOTS-1:0] entries_i,
  output logic                                     fq_ready_o,
  output fe_pkg::fetch_entry_t                     fetch_entry_o,
  output logic                                     fetch_entry_valid_o,
  input  logic                                     fetch_entry_ready_i
);
  import fe_pkg::*;

  fetch_entry_t [FQ_DEPTH-1:0]      mem_q;
  logic [FQ_PTR_W-1:0]              wr_ptr_q, rd_ptr_q;
  logic [FQ_CNT_W-1:0]              count_q;
  logic [FQ_CNT_W-1:0]              n_push;
  logic [SLOTS-1:0][FQ_PTR_W-1:0]   wr_idx;
  logic                             pop;

  // pushed entries pack densely, slot 0 first
  always_comb begin
    n_push = '0;
    for (int i = 0; i < SLOTS; i++) begin
      wr_idx[i] = wr_ptr_q + n_push[FQ_PTR_W-1:0];
      if (push_i[i]) n_push = n_push + FQ_CNT_W'(1);
    end
  end

  assign fetch_entry_valid_o = (count_q != '0);
  assign fetch_entry_o       = mem_q[rd_ptr_q];
  assign pop                 = fetch_entry_valid_o & fetch_entry_ready_i;
  // low watermark leaves room for three requests in flight
  assign fq_ready_o          = (count_q <= FQ_CNT_W'(FQ_LOW_MARK));

  // ----------------------------------------
  // pointers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + n_push[FQ_PTR_W-1:0];
      rd_ptr_q <= rd_ptr_q + FQ_PTR_W'(pop);
      count_q  <= count_q + n_push - FQ_CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < SLOTS; i++) begin
      if (push_i[i]) mem_q[wr_idx[i]] <= entries_i[i];
    end
  end

endmodule

//--- pc_gen.sv
`timescale 1ns/100ps

module pc_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [fe_pkg::XLEN-1:0] boot_addr_i,
  // back end redirects
  input  fe_pkg::resolve_t        resolve_i,
  input  logic                    eret_i,
  input  logic [fe_pkg::XLEN-1:0] epc_i,
  input  logic                    ex_valid_i,
  input  logic [fe_pkg::XLEN-1:0] trap_vector_i,
  input  logic                    set_pc_commit_i,
  input  logic [fe_pkg::XLEN-1:0] pc_commit_i,
  input  logic                    halt_i,
  // taken prediction on the held line
  input  logic                    bp_valid_i,
  input  logic [fe_pkg::XLEN-1:0] bp_target_i,
  input  logic                    fq_ready_i,
  output logic                    fetch_req_o,
  output logic [fe_pkg::XLEN-1:0] fetch_addr_o,
  output logic [fe_pkg::XLEN-1:0] req_addr_q_o,
  output logic                    drop_o,
  output logic                    flush_o
);
  import fe_pkg::*;

  logic [XLEN-1:0] npc_d, npc_q;
  logic [XLEN-1:0] fetch_pc;
  logic            boot_load_q;
  logic            mispredict;
  logic            redirect;

  assign mispredict = resolve_i.valid & resolve_i.mispredict;
  assign redirect   = mispredict | eret_i | ex_valid_i | set_pc_commit_i;

  // boot address on the first cycle, a taken target overrides
  always_comb begin
    fetch_pc = boot_load_q ? boot_addr_i : npc_q;
    if (bp_valid_i) begin
      fetch_pc = bp_target_i;
    end
  end

  // ----------------------------------------
  // memory request
  // ----------------------------------------
  // a request in a redirect cycle would come back wrong path
  assign fetch_req_o  = rst_ni & fq_ready_i & ~redirect;
  assign fetch_addr_o = fetch_pc & ~XLEN'(LINE_BYTES - 1);
  // response now in flight is stale on redirect or taken jump
  assign drop_o       = redirect | bp_valid_i;
  assign flush_o      = redirect;

  // next pc, later redirects win
  always_comb begin
    npc_d = fetch_pc;
    if (fetch_req_o) npc_d = fetch_addr_o + XLEN'(LINE_BYTES);
    if (mispredict) npc_d = resolve_i.target;
    if (eret_i) npc_d = epc_i;
    if (ex_valid_i) npc_d = trap_vector_i;
    // halted commit restarts at the instruction itself
    if (set_pc_commit_i) npc_d = halt_i ? pc_commit_i : pc_commit_i + XLEN'(4);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_load_q <= 1'b1;
      npc_q       <= '0;
    end else begin
      boot_load_q <= 1'b0;
      npc_q       <= npc_d;
    end
  end

  // full pc of the request, bit 2 tells fetch_stage the entry slot
  always_ff @(posedge clk_i) begin
    req_addr_q_o <= fetch_pc;
  end

endmodule

//--- branch_predict.sv
`timescale 1ns/100ps

module branch_predict (
  input  fe_pkg::fetch_slot_t  [fe_pkg::SLOTS-1:0] slots_i,
  input  fe_pkg::scan_t        [fe_pkg::SLOTS-1:0] scan_i,
  input  fe_pkg::bht_pred_t    [fe_pkg::SLOTS-1:0] bht_pred_i,
  output logic                                    bp_valid_o,
  output logic [fe_pkg::XLEN-1:0]                 bp_target_o,
  output logic [fe_pkg::SLOTS-1:0]                push_o,
  output fe_pkg::fetch_entry_t [fe_pkg::SLOTS-1:0] entries_o
);
  import fe_pkg::*;

  logic [SLOTS-1:0] taken;

  // per slot taken decision
  always_comb begin
    for (int i = 0; i < SLOTS; i++) begin
      if (!slots_i[i].valid) begin
        taken[i] = 1'b0;
      end else if (scan_i[i].is_jal) begin
        taken[i] = 1'b1;
      end else if (scan_i[i].is_branch) begin
        // dynamic counter if present, else backward taken
        taken[i] = bht_pred_i[i].valid ? bht_pred_i[i].taken
                                       : scan_i[i].imm[XLEN-1];
      end else begin
        taken[i] = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // lowest taken slot wins
  // ----------------------------------------
  always_comb begin
    bp_valid_o  = 1'b0;
    bp_target_o = '0;
    push_o      = '0;
    for (int i = 0; i < SLOTS; i++) begin
      entries_o[i].pc       = slots_i[i].pc;
      entries_o[i].instr    = slots_i[i].instr;
      entries_o[i].bp_taken = taken[i];
      // slots after a taken one are shadowed
      if (slots_i[i].valid && !bp_valid_o) begin
        push_o[i] = 1'b1;
        if (taken[i]) begin
          bp_valid_o  = 1'b1;
          bp_target_o = slots_i[i].pc + scan_i[i].imm;
        end
      end
    end
  end

endmodule

//--- bht.sv
`timescale 1ns/100ps

module bht (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         flush_bp_i,
  input  logic [fe_pkg::SLOTS-1:0][fe_pkg::XLEN-1:0]   pc_i,
  output fe_pkg::bht_pred_t [fe_pkg::SLOTS-1:0]         pred_o,
  input  fe_pkg::resolve_t                             resolve_i
);
  import fe_pkg::*;

  logic [BHT_ENTRIES-1:0]      valid_q;
  logic [BHT_ENTRIES-1:0][1:0] cnt_q;
  logic [BHT_IDX_W-1:0]        upd_idx;
  logic                        upd;

  // read ports
  always_comb begin
    for (int i = 0; i < SLOTS; i++) begin
      pred_o[i].valid = valid_q[pc_i[i][BHT_IDX_W+1:2]];
      pred_o[i].taken = cnt_q[pc_i[i][BHT_IDX_W+1:2]][1];
    end
  end

  // ----------------------------------------
  // training
  // ----------------------------------------
  assign upd     = resolve_i.valid & resolve_i.is_branch;
  assign upd_idx = resolve_i.pc[BHT_IDX_W+1:2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_bp_i) begin
      valid_q <= '0;
    end else if (upd) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // counters are meaningless until the entry is valid
  always_ff @(posedge clk_i) begin
    if (upd) begin
      if (!valid_q[upd_idx]) begin
        // first outcome seeds a weak state
        cnt_q[upd_idx] <= resolve_i.taken ? 2'b10 : 2'b01;
      end else if (resolve_i.taken) begin
        if (cnt_q[upd_idx] != 2'b11) cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'b01;
      end else begin
        if (cnt_q[upd_idx] != 2'b00) cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'b01;
      end
    end
  end

endmodule

//--- fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   fetch_valid_i,
  input  logic [fe_pkg::FETCH_WIDTH-1:0]         fetch_data_i,
  input  logic [fe_pkg::XLEN-1:0]                fetch_addr_i,
  input  logic                                   drop_i,
  input  logic                                   flush_i,
  output fe_pkg::fetch_slot_t [fe_pkg::SLOTS-1:0] slots_o
);
  import fe_pkg::*;

  logic                   line_valid_q;
  logic [FETCH_WIDTH-1:0] line_q;
  logic [XLEN-1:0]        addr_q;
  logic [XLEN-1:0]        line_base;

  // held line lives one cycle only
  // a response arriving while drop is high is wrong path
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_valid_q <= 1'b0;
    end else if (flush_i) begin
      line_valid_q <= 1'b0;
    end else begin
      line_valid_q <= fetch_valid_i & ~drop_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_valid_i) begin
      line_q <= fetch_data_i;
      addr_q <= fetch_addr_i;
    end
  end

  assign line_base = addr_q & ~XLEN'(LINE_BYTES - 1);

  // split the line into slots
  // slots below the requested word were jumped over
  always_comb begin
    for (int i = 0; i < SLOTS; i++) begin
      slots_o[i].pc    = line_base + XLEN'(4 * i);
      slots_o[i].instr = line_q[i*XLEN +: XLEN];
      slots_o[i].valid = line_valid_q & (i >= int'(addr_q[SLOT_IDX_W+1:2]));
    end
  end

endmodule

//--- instr_scan.sv
`timescale 1ns/100ps

module instr_scan (
  input  logic [fe_pkg::XLEN-1:0] instr_i,
  output fe_pkg::scan_t           scan_o
);
  import fe_pkg::*;

  opcode_e opc;

  // opcode group
  always_comb begin
    case (instr_i[6:0])
      OPC_BRANCH: opc = BRANCH;
      OPC_JAL:    opc = JAL;
      OPC_JALR:   opc = JALR;
      default:    opc = OTHER;
    endcase
  end

  always_comb begin
    scan_o = '0;
    case (opc)
      BRANCH: begin
        scan_o.is_branch = 1'b1;
        // b-type offset, bit 0 always zero
        scan_o.imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                      instr_i[11:8], 1'b0};
      end
      JAL: begin
        scan_o.is_jal = 1'b1;
        // j-type offset
        scan_o.imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                      instr_i[30:21], 1'b0};
      end
      // target comes from a register, not predicted
      // so the fetch simply runs on sequentially
      JALR: scan_o = '0;
      default: scan_o = '0;
    endcase
  end

endmodule

//--- fe_pkg.sv
package fe_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  // address and instruction width
  localparam int unsigned XLEN        = 32;
  // one memory line holds SLOTS instructions
  localparam int unsigned FETCH_WIDTH = 64;
  localparam int unsigned SLOTS       = 2;
  localparam int unsigned LINE_BYTES  = FETCH_WIDTH / 8;
  localparam int unsigned SLOT_IDX_W  = $clog2(SLOTS);
  // history table, indexed by pc[5:2]
  localparam int unsigned BHT_ENTRIES = 16;
  localparam int unsigned BHT_IDX_W   = $clog2(BHT_ENTRIES);
  // fetch queue; requests only while count <= FQ_LOW_MARK
  localparam int unsigned FQ_DEPTH    = 8;
  localparam int unsigned FQ_LOW_MARK = 2;
  localparam int unsigned FQ_PTR_W    = $clog2(FQ_DEPTH);
  localparam int unsigned FQ_CNT_W    = $clog2(FQ_DEPTH + 1);

  // rv32 major opcodes seen by the scanner
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // ----------------------------------------
  // types
  // ----------------------------------------
  typedef enum logic [1:0] {
    BRANCH,
    JAL,
    JALR,
    OTHER
  } opcode_e;

  // one position of a fetched line
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
  } fetch_slot_t;

  // scanner result, imm already sign extended
  typedef struct packed {
    logic            is_branch;
    logic            is_jal;
    logic [XLEN-1:0] imm;
  } scan_t;

  typedef struct packed {
    logic valid;
    logic taken;
  } bht_pred_t;

  // branch outcome from the back end
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic            is_branch;
    logic            taken;
    logic            mispredict;
    logic [XLEN-1:0] target;
  } resolve_t;

  // entry handed to decode
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    logic            bp_taken;
  } fetch_entry_t;

endpackage
